// File: hdl/ta_defines.svh
`ifndef TA_DEFINES_SVH
`define TA_DEFINES_SVH

// Board geometry
`define TA_BOARD_N     19
`define TA_CELL_W      2
`define TA_BOARD_W     (`TA_BOARD_N * `TA_BOARD_N * `TA_CELL_W)

// Diagonals shorter than 6 cells are never scanned
`define TA_DIAG_MAX    13

// 19 rows, 19 columns, 27 diagonals, 27 anti-diagonals
`define TA_NUM_LINES   92
`define TA_LINE_IDX_W  7

// Board totals
`define TA_COUNT_W     8

`endif

// File: hdl/ta_board_pkg.sv
`include "ta_defines.svh"

package ta_board_pkg;

// Cell encoding on the board bus where 3 counts as empty
typedef enum logic [`TA_CELL_W-1:0]
{
	CELL_EMPTY = 2'd0,
	CELL_BLACK = 2'd1,
	CELL_WHITE = 2'd2,
	CELL_RSVD  = 2'd3
} cell_t;

// Scan order of the line groups
typedef enum logic [1:0]
{
	DIR_ROW  = 2'd0,
	DIR_COL  = 2'd1,
	DIR_DIAG = 2'd2,
	DIR_ANTI = 2'd3
} line_dir_t;

endpackage

// File: hdl/ta_result_pkg.sv
`include "ta_defines.svh"

package ta_result_pkg;

// Board total
typedef logic [`TA_COUNT_W-1:0] count_t;

// Threats of one kind within a single line
typedef logic [3:0] line_count_t;

typedef enum logic [1:0]
{
	SEQ_IDLE  = 2'd0,
	SEQ_SCAN  = 2'd1,
	SEQ_DRAIN = 2'd2
} seq_state_t;

endpackage

// File: hdl/line_sequencer.sv
`timescale 1ns/1ps
`include "ta_defines.svh"

module line_sequencer import ta_board_pkg::*, ta_result_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      analyze,
	output logic      busy,
	output logic      done,
	output logic      scan_start,
	output logic      line_strobe,
	output line_dir_t line_dir,
	output logic [4:0] line_pos
);

seq_state_t state;
logic [`TA_LINE_IDX_W-1:0] line_idx;
logic [1:0] drain_cnt;
logic [4:0] last_pos;

// Rows and columns have 19 positions, both diagonal groups 27
assign last_pos = (line_dir == DIR_ROW || line_dir == DIR_COL) ?
	5'(`TA_BOARD_N - 1) : 5'(2 * `TA_DIAG_MAX);

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		state       <= SEQ_IDLE;
		busy        <= 1'b0;
		done        <= 1'b0;
		scan_start  <= 1'b0;
		line_strobe <= 1'b0;
		line_dir    <= DIR_ROW;
		line_pos    <= '0;
		line_idx    <= '0;
		drain_cnt   <= '0;
	end
	else
	begin
		done       <= 1'b0;
		scan_start <= 1'b0;
		case (state)
		SEQ_IDLE:
		begin
			if (analyze)
			begin
				state       <= SEQ_SCAN;
				busy        <= 1'b1;
				scan_start  <= 1'b1;
				line_strobe <= 1'b1;
				line_dir    <= DIR_ROW;
				line_pos    <= '0;
				line_idx    <= '0;
			end
		end
		SEQ_SCAN:
		begin
			line_idx <= line_idx + 1'b1;
			if (line_idx == `TA_LINE_IDX_W'(`TA_NUM_LINES - 1))
			begin
				state       <= SEQ_DRAIN;
				line_strobe <= 1'b0;
				drain_cnt   <= '0;
			end
			else if (line_pos == last_pos)
			begin
				line_dir <= line_dir.next();
				line_pos <= '0;
			end
			else
				line_pos <= line_pos + 1'b1;
		end
		SEQ_DRAIN:
		begin
			// Extractor and scanner still hold the last two lines
			drain_cnt <= drain_cnt + 1'b1;
			if (drain_cnt == 2'd2)
			begin
				state <= SEQ_IDLE;
				busy  <= 1'b0;
				done  <= 1'b1;
			end
		end
		default:
			state <= SEQ_IDLE;
		endcase
	end
end

endmodule

// File: hdl/line_extractor.sv
`timescale 1ns/1ps
`include "ta_defines.svh"

module line_extractor import ta_board_pkg::*;
(
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   analyze,
	input  logic                   busy,
	input  logic [`TA_BOARD_W-1:0] board,
	input  logic                   line_strobe,
	input  line_dir_t              line_dir,
	input  logic [4:0]             line_pos,
	output cell_t                  line_cells [`TA_BOARD_N],
	output logic                   cells_valid
);

logic [`TA_BOARD_W-1:0] board_q;
cell_t line_next [`TA_BOARD_N];

// Snapshot of the board for the whole scan
always_ff @(posedge clk)
begin
	if (analyze && !busy)
		board_q <= board;
end

////////////////////////////////////////////////////////////////////////////
// Cell gather along one line
////////////////////////////////////////////////////////////////////////////

always_comb
begin
	int pos;
	int row_base;
	int col_base;
	int col_step;
	int row_step;
	int r;
	int c;
	pos = int'(line_pos);
	row_step = (line_dir == DIR_ROW) ? 0 : 1;
	col_step = (line_dir == DIR_COL) ? 0 : ((line_dir == DIR_ANTI) ? -1 : 1);
	case (line_dir)
	DIR_ROW:
	begin
		row_base = pos;
		col_base = 0;
	end
	DIR_COL:
	begin
		row_base = 0;
		col_base = pos;
	end
	DIR_DIAG:
	begin
		// Offset col - row runs from -13 to +13
		row_base = (pos < `TA_DIAG_MAX) ? `TA_DIAG_MAX - pos : 0;
		col_base = row_base + pos - `TA_DIAG_MAX;
	end
	default:
	begin
		// Row + col runs from 5 to 31
		row_base = (pos > `TA_DIAG_MAX) ? pos - `TA_DIAG_MAX : 0;
		col_base = pos + (`TA_BOARD_N - 1 - `TA_DIAG_MAX) - row_base;
	end
	endcase
	for (int i = 0; i < `TA_BOARD_N; i++)
	begin
		r = row_base + i * row_step;
		c = col_base + i * col_step;
		if (r >= 0 && r < `TA_BOARD_N && c >= 0 && c < `TA_BOARD_N)
			line_next[i] = cell_t'(board_q[`TA_CELL_W * (r * `TA_BOARD_N + c) +: `TA_CELL_W]);
		else
			line_next[i] = CELL_EMPTY;
	end
end

always_ff @(posedge clk)
begin
	if (line_strobe)
		line_cells <= line_next;
end

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
		cells_valid <= 1'b0;
	else
		cells_valid <= line_strobe;
end

endmodule

// File: hdl/run_scanner.sv
`timescale 1ns/1ps
`include "ta_defines.svh"

module run_scanner import ta_board_pkg::*, ta_result_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  cell_t       line_cells [`TA_BOARD_N],
	input  logic        cells_valid,
	output line_count_t t4_b,
	output line_count_t t3_b,
	output line_count_t t2_b,
	output line_count_t t4_w,
	output line_count_t t3_w,
	output line_count_t t2_w,
	output logic        counts_valid
);

line_count_t tally_b [2:4];
line_count_t tally_w [2:4];

always_comb
begin
	cell_t padded [`TA_BOARD_N + 1];
	cell_t run_col;
	int run_len;
	// Reserved code reads as empty and one empty cell closes the last run
	for (int i = 0; i < `TA_BOARD_N; i++)
		padded[i] = (line_cells[i] == CELL_RSVD) ? CELL_EMPTY : line_cells[i];
	padded[`TA_BOARD_N] = CELL_EMPTY;
	tally_b = '{default: '0};
	tally_w = '{default: '0};
	run_col = CELL_EMPTY;
	run_len = 0;
	for (int i = 0; i <= `TA_BOARD_N; i++)
	begin
		if (padded[i] == run_col && padded[i] != CELL_EMPTY)
			run_len = run_len + 1;
		else
		begin
			// Only exact runs of 2, 3 or 4 count
			if (run_len >= 2 && run_len <= 4)
			begin
				if (run_col == CELL_BLACK)
					tally_b[run_len] = tally_b[run_len] + 1'b1;
				else
					tally_w[run_len] = tally_w[run_len] + 1'b1;
			end
			run_col = padded[i];
			run_len = (padded[i] == CELL_EMPTY) ? 0 : 1;
		end
	end
end

always_ff @(posedge clk)
begin
	t4_b <= tally_b[4];
	t3_b <= tally_b[3];
	t2_b <= tally_b[2];
	t4_w <= tally_w[4];
	t3_w <= tally_w[3];
	t2_w <= tally_w[2];
end

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
		counts_valid <= 1'b0;
	else
		counts_valid <= cells_valid;
end

endmodule

// File: hdl/threat_accumulator.sv
`timescale 1ns/1ps

module threat_accumulator import ta_result_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        scan_start,
	input  logic        counts_valid,
	input  line_count_t t4_b,
	input  line_count_t t3_b,
	input  line_count_t t2_b,
	input  line_count_t t4_w,
	input  line_count_t t3_w,
	input  line_count_t t2_w,
	output count_t      num_t4_b,
	output count_t      num_t3_b,
	output count_t      num_t2_b,
	output count_t      num_t4_w,
	output count_t      num_t3_w,
	output count_t      num_t2_w
);

// Totals hold between scans
always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		num_t4_b <= '0;
		num_t3_b <= '0;
		num_t2_b <= '0;
		num_t4_w <= '0;
		num_t3_w <= '0;
		num_t2_w <= '0;
	end
	else if (scan_start)
	begin
		num_t4_b <= '0;
		num_t3_b <= '0;
		num_t2_b <= '0;
		num_t4_w <= '0;
		num_t3_w <= '0;
		num_t2_w <= '0;
	end
	else if (counts_valid)
	begin
		num_t4_b <= num_t4_b + count_t'(t4_b);
		num_t3_b <= num_t3_b + count_t'(t3_b);
		num_t2_b <= num_t2_b + count_t'(t2_b);
		num_t4_w <= num_t4_w + count_t'(t4_w);
		num_t3_w <= num_t3_w + count_t'(t3_w);
		num_t2_w <= num_t2_w + count_t'(t2_w);
	end
end

endmodule

// File: hdl/threat_analyzer.sv
`timescale 1ns/1ps
`include "ta_defines.svh"

module threat_analyzer import ta_board_pkg::*, ta_result_pkg::*;
(
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   analyze,
	input  logic [`TA_BOARD_W-1:0] board,
	output logic                   busy,
	output logic                   done,
	output count_t                 num_t4_b,
	output count_t                 num_t3_b,
	output count_t                 num_t2_b,
	output count_t                 num_t4_w,
	output count_t                 num_t3_w,
	output count_t                 num_t2_w
);

logic scan_start;
logic line_strobe;
line_dir_t line_dir;
logic [4:0] line_pos;
cell_t line_cells [`TA_BOARD_N];
logic cells_valid;
line_count_t t4_b;
line_count_t t3_b;
line_count_t t2_b;
line_count_t t4_w;
line_count_t t3_w;
line_count_t t2_w;
logic counts_valid;

////////////////////////////////////////////////////////////////////////////
// Sequencer -> extractor -> scanner -> accumulator
////////////////////////////////////////////////////////////////////////////

line_sequencer line_sequencer_inst (.clk, .arst_n, .analyze, .busy, .done, .scan_start,
	.line_strobe, .line_dir, .line_pos);

line_extractor line_extractor_inst (.clk, .arst_n, .analyze, .busy, .board, .line_strobe,
	.line_dir, .line_pos, .line_cells, .cells_valid);

run_scanner run_scanner_inst (.clk, .arst_n, .line_cells, .cells_valid, .t4_b, .t3_b, .t2_b,
	.t4_w, .t3_w, .t2_w, .counts_valid);

threat_accumulator threat_accumulator_inst (.clk, .arst_n, .scan_start, .counts_valid,
	.t4_b, .t3_b, .t2_b, .t4_w, .t3_w, .t2_w, .num_t4_b, .num_t3_b, .num_t2_b,
	.num_t4_w, .num_t3_w, .num_t2_w);

endmodule

// File: verification/threat_analyzer_properties.sv
`timescale 1ns/1ps

module threat_analyzer_properties
(
	input logic clk,
	input logic arst_n,
	input logic analyze,
	input logic busy,
	input logic done,
	input logic line_strobe
);

int fail_count;

initial
	fail_count = 0;

// Done is a single-cycle pulse
done_single: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
	else
	begin
		$error("done stayed high for more than one cycle");
		fail_count = fail_count + 1;
	end

// Busy drops on the same edge that raises done
busy_falls_at_done: assert property (@(posedge clk) disable iff (!arst_n)
	done |-> $fell(busy))
	else
	begin
		$error("busy did not fall together with done");
		fail_count = fail_count + 1;
	end

busy_falls_only_at_done: assert property (@(posedge clk) disable iff (!arst_n)
	$fell(busy) |-> done)
	else
	begin
		$error("busy fell without done");
		fail_count = fail_count + 1;
	end

strobe_in_scan: assert property (@(posedge clk) disable iff (!arst_n)
	line_strobe |-> busy)
	else
	begin
		$error("line_strobe seen while not busy");
		fail_count = fail_count + 1;
	end

// Done is registered 95 edges after the accepted analyze and sampled one edge later
done_latency: assert property (@(posedge clk) disable iff (!arst_n)
	(analyze && !busy) |-> ##96 done)
	else
	begin
		$error("done did not follow an accepted analyze after 95 cycles");
		fail_count = fail_count + 1;
	end

endmodule

bind line_sequencer threat_analyzer_properties threat_analyzer_properties_inst (.clk, .arst_n,
	.analyze, .busy, .done, .line_strobe);

// File: verification/threat_analyzer_tb.sv
`timescale 1ns/1ps
`include "ta_defines.svh"

module threat_analyzer_tb;

// 26 analyses in total over the six tests
localparam int NUM_RUNS = 26;
localparam int TIMEOUT_CYCLES = NUM_RUNS * 110 + 100;

logic clk;
logic arst_n;
logic analyze;
logic [`TA_BOARD_W-1:0] board;
logic busy;
logic done;
logic [`TA_COUNT_W-1:0] num_t4_b;
logic [`TA_COUNT_W-1:0] num_t3_b;
logic [`TA_COUNT_W-1:0] num_t2_b;
logic [`TA_COUNT_W-1:0] num_t4_w;
logic [`TA_COUNT_W-1:0] num_t3_w;
logic [`TA_COUNT_W-1:0] num_t2_w;

// Expected totals in slot order t4_b t3_b t2_b t4_w t3_w t2_w
logic [47:0] exp_tot;
int cycle_count = 0;
int done_count = 0;
int done_cycle = 0;
int start_count;
int start_cycle;
int errors = 0;
int checks = 0;
int test_num = 0;
int err_mark;
int assert_fails;
int seed;

threat_analyzer threat_analyzer_inst (.clk, .arst_n, .analyze, .board, .busy, .done,
	.num_t4_b, .num_t3_b, .num_t2_b, .num_t4_w, .num_t3_w, .num_t2_w);

always #50 clk = ~clk;

always @(posedge clk)
begin
	cycle_count = cycle_count + 1;
	if (cycle_count >= TIMEOUT_CYCLES)
	begin
		$display("Simulation stopped: no result within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end
end

task automatic check_val(input string what, input int got, input int expected);
	checks = checks + 1;
	if (got != expected)
	begin
		errors = errors + 1;
		$display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, expected);
	end
endtask

task automatic check_totals();
	check_val("num_t4_b", num_t4_b, exp_tot[0 +: 8]);
	check_val("num_t3_b", num_t3_b, exp_tot[8 +: 8]);
	check_val("num_t2_b", num_t2_b, exp_tot[16 +: 8]);
	check_val("num_t4_w", num_t4_w, exp_tot[24 +: 8]);
	check_val("num_t3_w", num_t3_w, exp_tot[32 +: 8]);
	check_val("num_t2_w", num_t2_w, exp_tot[40 +: 8]);
endtask

// Compare on every done pulse
always @(negedge clk)
begin
	if (done)
	begin
		done_count = done_count + 1;
		done_cycle = cycle_count;
		check_val("busy at done", busy, 0);
		check_totals();
	end
end

////////////////////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////////////////////

function automatic int cell_at(input logic [`TA_BOARD_W-1:0] b, input int r, input int c);
	logic [1:0] v;
	if (r < 0 || r >= `TA_BOARD_N || c < 0 || c >= `TA_BOARD_N)
		return 0;
	v = b[2 * (r * `TA_BOARD_N + c) +: 2];
	return (v == 2'd3) ? 0 : int'(v);
endfunction

function automatic logic [47:0] ref_totals(input logic [`TA_BOARD_W-1:0] b);
	logic [47:0] tot;
	int dr [4];
	int dc [4];
	int colour;
	int span;
	int len;
	int slot;
	tot = '0;
	dr = '{0, 1, 1, 1};
	dc = '{1, 0, 1, -1};
	for (int d = 0; d < 4; d++)
	begin
		for (int r = 0; r < `TA_BOARD_N; r++)
		begin
			for (int c = 0; c < `TA_BOARD_N; c++)
			begin
				colour = cell_at(b, r, c);
				// Length of the whole line through (r,c)
				if (d == 2)
					span = (c >= r) ? `TA_BOARD_N - (c - r) : `TA_BOARD_N - (r - c);
				else if (d == 3)
					span = (r + c < `TA_BOARD_N) ? r + c + 1 : 2 * `TA_BOARD_N - 1 - (r + c);
				else
					span = `TA_BOARD_N;
				if (colour != 0 && span >= 6 && cell_at(b, r - dr[d], c - dc[d]) != colour)
				begin
					len = 0;
					while (cell_at(b, r + len * dr[d], c + len * dc[d]) == colour)
						len = len + 1;
					if (len >= 2 && len <= 4)
					begin
						slot = ((colour == 1) ? 0 : 3) + 4 - len;
						tot[8 * slot +: 8] = tot[8 * slot +: 8] + 8'd1;
					end
				end
			end
		end
	end
	return tot;
endfunction

////////////////////////////////////////////////////////////////////////////
// Stimulus helpers
////////////////////////////////////////////////////////////////////////////

task automatic put_cell(input int r, input int c, input logic [1:0] v);
	board[2 * (r * `TA_BOARD_N + c) +: 2] = v;
endtask

task automatic random_board(input int density);
	int rnd;
	for (int i = 0; i < `TA_BOARD_N * `TA_BOARD_N; i++)
	begin
		rnd = $random(seed);
		if ((rnd[7:0] % 100) < density)
			board[2 * i +: 2] = rnd[8] ? 2'd1 : 2'd2;
		else
			board[2 * i +: 2] = (rnd[15:12] == 4'd0) ? 2'd3 : 2'd0;
	end
endtask

task automatic start_analysis();
	start_count = done_count;
	exp_tot = ref_totals(board);
	analyze = 1'b1;
	start_cycle = cycle_count;
	@(negedge clk);
	analyze = 1'b0;
endtask

task automatic wait_result();
	while (done_count == start_count)
		@(posedge clk);
	@(negedge clk);
	check_val("done latency", done_cycle - start_cycle - 1, 95);
endtask

task automatic begin_test();
	test_num = test_num + 1;
	err_mark = errors;
	board = '0;
endtask

task automatic end_test(input string name);
	$display("test %0d %s: %s", test_num, name, (errors == err_mark) ? "passed" : "failed");
endtask

initial
begin
	clk = 1'b0;
	arst_n = 1'b0;
	analyze = 1'b0;
	board = '0;
	exp_tot = '0;
	seed = 32'h4aa0;
	repeat (16) @(negedge clk);
	arst_n = 1'b1;
	@(negedge clk);

	begin_test();
	check_val("busy after reset", busy, 0);
	check_val("done after reset", done, 0);
	check_totals();
	start_analysis();
	wait_result();
	end_test("reset and empty board");

	begin_test();
	put_cell(3, 0, 2'd1);
	put_cell(3, 1, 2'd1);
	for (int c = 4; c <= 6; c++)
		put_cell(3, c, 2'd1);
	for (int c = 9; c <= 12; c++)
		put_cell(3, c, 2'd1);
	start_analysis();
	check_val("reference t4_b", exp_tot[0 +: 8], 1);
	check_val("reference t3_b", exp_tot[8 +: 8], 1);
	check_val("reference t2_b", exp_tot[16 +: 8], 1);
	wait_result();
	end_test("black runs in one row");

	begin_test();
	for (int c = 0; c <= 4; c++)
		put_cell(5, c, 2'd1);
	for (int c = 0; c <= 5; c++)
		put_cell(7, c, 2'd1);
	for (int c = 0; c <= 5; c++)
		put_cell(9, c, (c == 2) ? 2'd2 : 2'd1);
	for (int c = 0; c <= 4; c++)
		put_cell(11, c, (c == 2) ? 2'd3 : 2'd1);
	start_analysis();
	wait_result();
	end_test("exact run length");

	begin_test();
	// Shortest scanned diagonal and anti-diagonal
	for (int r = 0; r <= 2; r++)
		put_cell(r, r + 13, 2'd1);
	for (int r = 0; r <= 3; r++)
		put_cell(r, 5 - r, 2'd2);
	// Five-cell lines lie outside the scan
	for (int r = 14; r <= 16; r++)
		put_cell(r, r - 14, 2'd1);
	for (int r = 15; r <= 18; r++)
		put_cell(r, 32 - r, 2'd2);
	put_cell(8, 8, 2'd1);
	put_cell(9, 9, 2'd1);
	start_analysis();
	wait_result();
	end_test("diagonal lines");

	begin_test();
	for (int t = 0; t < 20; t++)
	begin
		random_board(10 + t * 4);
		start_analysis();
		wait_result();
	end
	end_test("random boards");

	begin_test();
	for (int c = 2; c <= 4; c++)
		put_cell(0, c, 2'd1);
	start_analysis();
	repeat (10) @(negedge clk);
	for (int r = 6; r <= 9; r++)
		put_cell(r, 10, 2'd2);
	analyze = 1'b1;
	@(negedge clk);
	analyze = 1'b0;
	wait_result();
	repeat (20) @(negedge clk);
	check_val("done pulses", done_count - start_count, 1);
	check_totals();
	start_analysis();
	wait_result();
	end_test("analyze while busy");

	assert_fails =
		threat_analyzer_inst.line_sequencer_inst.threat_analyzer_properties_inst.fail_count;
	if (assert_fails != 0)
	begin
		$display("Control strobe assertions failed %0d times", assert_fails);
		errors = errors + assert_fails;
	end
	$display("tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
	if (errors == 0)
		$display("TEST RESULT: PASS");
	else
		$display("TEST RESULT: FAIL");
	$finish;
end

endmodule

// File: all.f
+incdir+hdl
hdl/ta_board_pkg.sv
hdl/ta_result_pkg.sv
hdl/line_sequencer.sv
hdl/line_extractor.sv
hdl/run_scanner.sv
hdl/threat_accumulator.sv
hdl/threat_analyzer.sv
verification/threat_analyzer_properties.sv
verification/threat_analyzer_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run the threat analyzer testbench

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module threat_analyzer_tb \
	-f all.f -o threat_analyzer_sim &&
./obj_dir/threat_analyzer_sim +verilator+error+limit+100 > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "TEST RESULT: PASS" sim.log 2>/dev/null && echo "Simulation passed" && exit 0 ||
	{ echo "Simulation failed"; exit 1; }
